//--- gf_pkg.sv
package gf_pkg;

	// GF(2^7) with field polynomial x^7 + x + 1.
	localparam int gf_m = 7;

	// Low terms of the field polynomial, x + 1.
	localparam logic [gf_m-1:0] gf_poly = 7'b000_0011;

	localparam int rf_depth = 16;
	localparam int rf_addr_w = 4;

	// Requester 0 is the controller, 1 the multiplier and 2 the inverter.
	localparam int n_req = 3;

	typedef enum logic [2:0] {
		op_write,
		op_read,
		op_mul,
		op_sqr,
		op_inv
	} gf_op_e;

	// The inverter reads a single operand and never enters st_fetch_b.
	typedef enum logic [2:0] {
		st_idle,
		st_fetch_a,
		st_fetch_b,
		st_run,
		st_store
	} eng_state_e;

endpackage

//--- rf_bus_if.sv
`timescale 1ns/1ps

// One requester's port on the shared register-file bus.
interface rf_bus_if import gf_pkg::*; ();
	logic req;
	logic we;
	logic [rf_addr_w-1:0] addr;
	logic [gf_m-1:0] wdata;
	logic gnt;
	logic [gf_m-1:0] rdata;

	modport requester (
		output req,
		output we,
		output addr,
		output wdata,
		input gnt,
		input rdata
	);

	modport arbiter (
		input req,
		input we,
		input addr,
		input wdata,
		output gnt,
		output rdata
	);
endinterface

//--- gf_regfile.sv
`timescale 1ns/1ps

module gf_regfile import gf_pkg::*; (
	input logic clk,
	input logic reset,
	input logic en,
	input logic we,
	input logic [rf_addr_w-1:0] addr,
	input logic [gf_m-1:0] wdata,
	output logic [gf_m-1:0] rdata
);
	logic [gf_m-1:0] regs [rf_depth];

	// Read data shows up one cycle after the access.
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < rf_depth; i++) begin
				regs[i] <= '0;
			end
			rdata <= '0;
		end else if (en) begin
			if (we) begin
				regs[addr] <= wdata;
			end else begin
				rdata <= regs[addr];
			end
		end
	end
endmodule

//--- rf_arbiter.sv
`timescale 1ns/1ps

module rf_arbiter import gf_pkg::*; (
	input logic clk,
	input logic reset,
	rf_bus_if.arbiter ctrl_bus,
	rf_bus_if.arbiter mul_bus,
	rf_bus_if.arbiter inv_bus,
	output logic rf_en,
	output logic rf_we,
	output logic [rf_addr_w-1:0] rf_addr,
	output logic [gf_m-1:0] rf_wdata,
	input logic [gf_m-1:0] rf_rdata
);
	logic [n_req-1:0] req_vec;
	logic [n_req-1:0] gnt_vec;
	logic [$clog2(n_req)-1:0] ptr;
	logic [$clog2(n_req)-1:0] sel;

	assign req_vec = {inv_bus.req, mul_bus.req, ctrl_bus.req};
	assign rf_en = |req_vec;

	// Walk from the farthest requester back to the pointer, so the
	// last hit is the first one in round-robin order.
	always_comb begin
		int idx;
		sel = ptr;
		for (int k = n_req - 1; k >= 0; k--) begin
			idx = int'(ptr) + k;
			if (idx >= n_req)
				idx = idx - n_req;
			if (req_vec[idx])
				sel = idx[$clog2(n_req)-1:0];
		end
		gnt_vec = '0;
		gnt_vec[sel] = rf_en;
	end

	always_comb begin
		rf_we = ctrl_bus.we;
		rf_addr = ctrl_bus.addr;
		rf_wdata = ctrl_bus.wdata;
		if (gnt_vec[1]) begin
			rf_we = mul_bus.we;
			rf_addr = mul_bus.addr;
			rf_wdata = mul_bus.wdata;
		end else if (gnt_vec[2]) begin
			rf_we = inv_bus.we;
			rf_addr = inv_bus.addr;
			rf_wdata = inv_bus.wdata;
		end
	end

	assign ctrl_bus.gnt = gnt_vec[0];
	assign mul_bus.gnt = gnt_vec[1];
	assign inv_bus.gnt = gnt_vec[2];

	// Every requester sees the read data and takes it only after its own grant.
	assign ctrl_bus.rdata = rf_rdata;
	assign mul_bus.rdata = rf_rdata;
	assign inv_bus.rdata = rf_rdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			ptr <= '0;
		end else if (rf_en) begin
			ptr <= (sel == n_req - 1) ? '0 : sel + 1'b1;
		end
	end
endmodule

//--- gf_mul_engine.sv
`timescale 1ns/1ps

module gf_mul_engine import gf_pkg::*; (
	input logic clk,
	input logic reset,
	input logic go,
	input logic [rf_addr_w-1:0] src_a,
	input logic [rf_addr_w-1:0] src_b,
	input logic [rf_addr_w-1:0] dst,
	output logic busy,
	rf_bus_if.requester bus
);
	eng_state_e state;
	logic [rf_addr_w-1:0] sa;
	logic [rf_addr_w-1:0] sb;
	logic [rf_addr_w-1:0] sd;
	logic [gf_m-1:0] a_reg;
	logic [gf_m-1:0] b_reg;
	logic [gf_m-1:0] b_val;
	logic [gf_m-1:0] acc;
	logic [gf_m-1:0] acc_next;
	logic [2:0] cnt;
	logic cap;
	logic b_bit;

	assign busy = state != st_idle;

	assign bus.req = state == st_fetch_a || state == st_fetch_b || state == st_store;
	assign bus.we = state == st_store;
	assign bus.wdata = acc;

	always_comb begin
		case (state)
			st_fetch_a: bus.addr = sa;
			st_fetch_b: bus.addr = sb;
			default: bus.addr = sd;
		endcase
	end

	// Operand b is still on the bus in the first run cycle.
	assign b_val = cap ? bus.rdata : b_reg;
	assign b_bit = b_val[gf_m-1-cnt];

	// One Horner step, most significant bit of b first.
	assign acc_next = {acc[gf_m-2:0], 1'b0}
		^ (acc[gf_m-1] ? gf_poly : '0)
		^ (b_bit ? a_reg : '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			cnt <= '0;
			cap <= 1'b0;
		end else begin
			cap <= bus.gnt && !bus.we;
			case (state)
				st_idle: if (go) state <= st_fetch_a;
				st_fetch_a: if (bus.gnt) state <= st_fetch_b;
				st_fetch_b: if (bus.gnt) state <= st_run;
				st_run: begin
					cnt <= cnt + 3'd1;
					if (cnt == gf_m - 1) begin
						cnt <= '0;
						state <= st_store;
					end
				end
				st_store: if (bus.gnt) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (go && state == st_idle) begin
			sa <= src_a;
			sb <= src_b;
			sd <= dst;
			acc <= '0;
		end
		if (state == st_fetch_b && cap)
			a_reg <= bus.rdata;
		if (state == st_run) begin
			acc <= acc_next;
			if (cap)
				b_reg <= bus.rdata;
		end
	end
endmodule

//--- gf_inv_engine.sv
`timescale 1ns/1ps

module gf_inv_engine import gf_pkg::*; (
	input logic clk,
	input logic reset,
	input logic go,
	input gf_op_e op,
	input logic [rf_addr_w-1:0] src_a,
	input logic [rf_addr_w-1:0] dst,
	output logic busy,
	rf_bus_if.requester bus
);
	eng_state_e state;
	gf_op_e opc;
	logic [rf_addr_w-1:0] sa;
	logic [rf_addr_w-1:0] sd;
	logic [gf_m-1:0] a_reg;
	logic [gf_m-1:0] a_val;
	logic [gf_m-1:0] x;
	logic [gf_m-1:0] sq_out;
	logic [gf_m-1:0] mul_out;
	logic [3:0] cnt;
	logic cap;
	logic last;

	// Folds every term above x^6 back with x^7 = x + 1.
	function automatic logic [gf_m-1:0] gf_reduce(input logic [2*gf_m-2:0] p);
		logic [2*gf_m-2:0] r;
		r = p;
		for (int k = 2 * gf_m - 2; k >= gf_m; k--) begin
			if (r[k]) begin
				r[k] = 1'b0;
				r[k-gf_m +: gf_m] = r[k-gf_m +: gf_m] ^ gf_poly;
			end
		end
		return r[gf_m-1:0];
	endfunction

	function automatic logic [2*gf_m-2:0] gf_clmul(input logic [gf_m-1:0] a,
			input logic [gf_m-1:0] b);
		logic [2*gf_m-2:0] p;
		p = '0;
		for (int i = 0; i < gf_m; i++) begin
			if (b[i])
				p = p ^ ({{(gf_m-1){1'b0}}, a} << i);
		end
		return p;
	endfunction

	// Squaring is linear in GF(2^m), so it only spreads the bits apart.
	function automatic logic [gf_m-1:0] gf_square(input logic [gf_m-1:0] a);
		logic [2*gf_m-2:0] p;
		p = '0;
		for (int i = 0; i < gf_m; i++) begin
			p[2*i] = a[i];
		end
		return gf_reduce(p);
	endfunction

	assign busy = state != st_idle;

	assign bus.req = state == st_fetch_a || state == st_store;
	assign bus.we = state == st_store;
	assign bus.addr = (state == st_fetch_a) ? sa : sd;
	assign bus.wdata = x;

	assign a_val = cap ? bus.rdata : a_reg;
	assign sq_out = gf_square(opc == op_sqr ? a_val : x);
	assign mul_out = gf_reduce(gf_clmul(x, a_val));

	// a^126 starting from 1: multiply by a on even steps and square on odd
	// steps, twelve steps in all. A zero input stays zero throughout.
	assign last = opc == op_sqr || cnt == 2 * gf_m - 3;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			cnt <= '0;
			cap <= 1'b0;
		end else begin
			cap <= bus.gnt && !bus.we;
			case (state)
				st_idle: if (go) state <= st_fetch_a;
				st_fetch_a: if (bus.gnt) state <= st_run;
				st_run: begin
					cnt <= cnt + 4'd1;
					if (last) begin
						cnt <= '0;
						state <= st_store;
					end
				end
				st_store: if (bus.gnt) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (go && state == st_idle) begin
			opc <= op;
			sa <= src_a;
			sd <= dst;
			x <= gf_m'(1);
		end
		if (state == st_run) begin
			if (cap)
				a_reg <= bus.rdata;
			if (opc == op_sqr || cnt[0])
				x <= sq_out;
			else
				x <= mul_out;
		end
	end
endmodule

//--- gf_cmd_ctrl.sv
`timescale 1ns/1ps

module gf_cmd_ctrl import gf_pkg::*; (
	input logic clk,
	input logic reset,
	input logic cmd_start,
	input gf_op_e cmd_op,
	input logic [rf_addr_w-1:0] cmd_a,
	input logic [rf_addr_w-1:0] cmd_b,
	input logic [rf_addr_w-1:0] cmd_dst,
	input logic [gf_m-1:0] cmd_imm,
	output logic cmd_ready,
	output logic rd_valid,
	output logic [gf_m-1:0] rd_data,
	output logic mul_go,
	output logic inv_go,
	output gf_op_e inv_op,
	output logic [rf_addr_w-1:0] eng_src_a,
	output logic [rf_addr_w-1:0] eng_src_b,
	output logic [rf_addr_w-1:0] eng_dst,
	input logic mul_busy,
	input logic inv_busy,
	rf_bus_if.requester bus
);
	logic host_req;
	logic host_we;
	logic [rf_addr_w-1:0] host_addr;
	logic [gf_m-1:0] host_wdata;
	logic [rf_addr_w-1:0] mul_sa;
	logic [rf_addr_w-1:0] mul_sb;
	logic [rf_addr_w-1:0] mul_dst;
	logic [rf_addr_w-1:0] inv_sa;
	logic [rf_addr_w-1:0] inv_dst;
	logic is_mul;
	logic is_inv;
	logic is_host;
	logic uses_a;
	logic uses_b;
	logic uses_dst;
	logic mul_hit;
	logic inv_hit;
	logic accept;

	assign is_mul = cmd_op == op_mul;
	assign is_inv = cmd_op == op_sqr || cmd_op == op_inv;
	assign is_host = cmd_op == op_write || cmd_op == op_read;
	assign uses_a = cmd_op != op_write;
	assign uses_b = is_mul;
	assign uses_dst = cmd_op != op_read;

	// A busy engine owns its destination. Its sources are also held, since
	// they may not have been fetched yet.
	assign mul_hit = mul_busy && ((uses_a && cmd_a == mul_dst)
		|| (uses_b && cmd_b == mul_dst)
		|| (uses_dst && (cmd_dst == mul_dst || cmd_dst == mul_sa || cmd_dst == mul_sb)));
	assign inv_hit = inv_busy && ((uses_a && cmd_a == inv_dst)
		|| (uses_b && cmd_b == inv_dst)
		|| (uses_dst && (cmd_dst == inv_dst || cmd_dst == inv_sa)));

	assign cmd_ready = !host_req && !rd_valid && !mul_hit && !inv_hit
		&& !(is_mul && mul_busy) && !(is_inv && inv_busy)
		&& !(cmd_op == op_read && (mul_busy || inv_busy));

	assign accept = cmd_start && cmd_ready;

	assign mul_go = accept && is_mul;
	assign inv_go = accept && is_inv;
	assign inv_op = cmd_op;
	assign eng_src_a = cmd_a;
	assign eng_src_b = cmd_b;
	assign eng_dst = cmd_dst;

	assign bus.req = host_req;
	assign bus.we = host_we;
	assign bus.addr = host_addr;
	assign bus.wdata = host_wdata;
	assign rd_data = bus.rdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			host_req <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= bus.gnt && !host_we;
			if (bus.gnt)
				host_req <= 1'b0;
			else if (accept && is_host)
				host_req <= 1'b1;
		end
	end

	// Host reads take the register from cmd_a, writes go to cmd_dst.
	always_ff @(posedge clk) begin
		if (accept && is_host) begin
			host_we <= cmd_op == op_write;
			host_addr <= (cmd_op == op_write) ? cmd_dst : cmd_a;
			host_wdata <= cmd_imm;
		end
		if (mul_go) begin
			mul_sa <= cmd_a;
			mul_sb <= cmd_b;
			mul_dst <= cmd_dst;
		end
		if (inv_go) begin
			inv_sa <= cmd_a;
			inv_dst <= cmd_dst;
		end
	end
endmodule

//--- gf_coproc.sv
`timescale 1ns/1ps

module gf_coproc import gf_pkg::*; (
	input logic clk,
	input logic reset,
	input logic cmd_start,
	input gf_op_e cmd_op,
	input logic [rf_addr_w-1:0] cmd_a,
	input logic [rf_addr_w-1:0] cmd_b,
	input logic [rf_addr_w-1:0] cmd_dst,
	input logic [gf_m-1:0] cmd_imm,
	output logic cmd_ready,
	output logic rd_valid,
	output logic [gf_m-1:0] rd_data
);
	logic mul_go;
	logic inv_go;
	gf_op_e inv_op;
	logic [rf_addr_w-1:0] eng_src_a;
	logic [rf_addr_w-1:0] eng_src_b;
	logic [rf_addr_w-1:0] eng_dst;
	logic mul_busy;
	logic inv_busy;
	logic rf_en;
	logic rf_we;
	logic [rf_addr_w-1:0] rf_addr;
	logic [gf_m-1:0] rf_wdata;
	logic [gf_m-1:0] rf_rdata;

	rf_bus_if ctrl_bus ();
	rf_bus_if mul_bus ();
	rf_bus_if inv_bus ();

	gf_cmd_ctrl gf_cmd_ctrl_inst (
		.clk(clk),
		.reset(reset),
		.cmd_start(cmd_start),
		.cmd_op(cmd_op),
		.cmd_a(cmd_a),
		.cmd_b(cmd_b),
		.cmd_dst(cmd_dst),
		.cmd_imm(cmd_imm),
		.cmd_ready(cmd_ready),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.mul_go(mul_go),
		.inv_go(inv_go),
		.inv_op(inv_op),
		.eng_src_a(eng_src_a),
		.eng_src_b(eng_src_b),
		.eng_dst(eng_dst),
		.mul_busy(mul_busy),
		.inv_busy(inv_busy),
		.bus(ctrl_bus.requester)
	);

	gf_mul_engine gf_mul_engine_inst (
		.clk(clk),
		.reset(reset),
		.go(mul_go),
		.src_a(eng_src_a),
		.src_b(eng_src_b),
		.dst(eng_dst),
		.busy(mul_busy),
		.bus(mul_bus.requester)
	);

	gf_inv_engine gf_inv_engine_inst (
		.clk(clk),
		.reset(reset),
		.go(inv_go),
		.op(inv_op),
		.src_a(eng_src_a),
		.dst(eng_dst),
		.busy(inv_busy),
		.bus(inv_bus.requester)
	);

	rf_arbiter rf_arbiter_inst (
		.clk(clk),
		.reset(reset),
		.ctrl_bus(ctrl_bus.arbiter),
		.mul_bus(mul_bus.arbiter),
		.inv_bus(inv_bus.arbiter),
		.rf_en(rf_en),
		.rf_we(rf_we),
		.rf_addr(rf_addr),
		.rf_wdata(rf_wdata),
		.rf_rdata(rf_rdata)
	);

	gf_regfile gf_regfile_inst (
		.clk(clk),
		.reset(reset),
		.en(rf_en),
		.we(rf_we),
		.addr(rf_addr),
		.wdata(rf_wdata),
		.rdata(rf_rdata)
	);
endmodule

//--- tb_gf_coproc.sv
`timescale 1ns/1ps

module tb_gf_coproc import gf_pkg::*; ();
	localparam int n_cmds = 300;
	localparam int cycles_per_cmd = 40;
	localparam int max_cycles = n_cmds * cycles_per_cmd;

	// Low terms of x^7 + x + 1.
	localparam logic [gf_m-1:0] poly_low = 7'h03;

	logic clk;
	logic reset;
	logic cmd_start;
	gf_op_e cmd_op;
	logic [rf_addr_w-1:0] cmd_a;
	logic [rf_addr_w-1:0] cmd_b;
	logic [rf_addr_w-1:0] cmd_dst;
	logic [gf_m-1:0] cmd_imm;
	logic cmd_ready;
	logic rd_valid;
	logic [gf_m-1:0] rd_data;

	logic [gf_m-1:0] shadow [rf_depth];
	int seed;
	int cycles = 0;
	int cmd_count = 0;
	int n_reads = 0;
	int rd_pulses = 0;
	int checks = 0;
	int errors = 0;

	gf_coproc gf_coproc_inst (
		.clk(clk),
		.reset(reset),
		.cmd_start(cmd_start),
		.cmd_op(cmd_op),
		.cmd_a(cmd_a),
		.cmd_b(cmd_b),
		.cmd_dst(cmd_dst),
		.cmd_imm(cmd_imm),
		.cmd_ready(cmd_ready),
		.rd_valid(rd_valid),
		.rd_data(rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles.", max_cycles);
			$display("Checks: %0d, errors: %0d, commands: %0d", checks, errors, cmd_count);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	always @(posedge clk) begin
		if (!reset && rd_valid)
			rd_pulses <= rd_pulses + 1;
	end

	// Multiply by x, then fold x^7 back as x + 1.
	function automatic logic [gf_m-1:0] xtime(input logic [gf_m-1:0] v);
		return {v[gf_m-2:0], 1'b0} ^ (v[gf_m-1] ? poly_low : '0);
	endfunction

	// Shift-and-add multiply, least significant bit of b first.
	function automatic logic [gf_m-1:0] field_mul(input logic [gf_m-1:0] a,
			input logic [gf_m-1:0] b);
		logic [gf_m-1:0] acc;
		logic [gf_m-1:0] sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < gf_m; i++) begin
			if (b[i])
				acc = acc ^ sh;
			sh = xtime(sh);
		end
		return acc;
	endfunction

	function automatic logic [gf_m-1:0] field_inv(input logic [gf_m-1:0] a);
		logic [gf_m-1:0] r;
		r = 7'h01;
		for (int i = 0; i < (1 << gf_m) - 2; i++)
			r = field_mul(r, a);
		return r;
	endfunction

	function automatic logic [31:0] next_rand();
		return $random(seed);
	endfunction

	function automatic logic [rf_addr_w-1:0] rand_reg();
		logic [31:0] r;
		r = next_rand();
		return r[rf_addr_w-1:0];
	endfunction

	function automatic logic [gf_m-1:0] rand_val();
		logic [31:0] r;
		r = next_rand();
		return r[gf_m-1:0];
	endfunction

	function automatic logic [gf_m-1:0] rand_nonzero();
		logic [31:0] r;
		r = next_rand();
		return gf_m'(r[15:0] % 16'd127) + 1'b1;
	endfunction

	// Waits for cmd_ready, pulses cmd_start and updates the shadow registers.
	task automatic issue(input gf_op_e op, input logic [rf_addr_w-1:0] a,
			input logic [rf_addr_w-1:0] b, input logic [rf_addr_w-1:0] dst,
			input logic [gf_m-1:0] imm);
		cmd_op = op;
		cmd_a = a;
		cmd_b = b;
		cmd_dst = dst;
		cmd_imm = imm;
		cmd_start = 1'b0;
		@(negedge clk);
		while (!cmd_ready)
			@(negedge clk);
		cmd_start = 1'b1;
		@(negedge clk);
		cmd_start = 1'b0;
		cmd_count++;
		case (op)
			op_write: shadow[dst] = imm;
			op_mul: shadow[dst] = field_mul(shadow[a], shadow[b]);
			op_sqr: shadow[dst] = field_mul(shadow[a], shadow[a]);
			op_inv: shadow[dst] = field_inv(shadow[a]);
			default: ;
		endcase
	endtask

	task automatic write_reg(input logic [rf_addr_w-1:0] r, input logic [gf_m-1:0] v);
		issue(op_write, '0, '0, r, v);
	endtask

	task automatic read_check(input logic [rf_addr_w-1:0] r, input logic [gf_m-1:0] exp,
			input string what);
		logic [gf_m-1:0] got;
		issue(op_read, r, '0, '0, '0);
		n_reads++;
		while (!rd_valid)
			@(negedge clk);
		got = rd_data;
		checks++;
		assert (got == exp)
		else begin
			errors++;
			$display("Error: %0d ns: %s, r%0d read 0x%02h, expected 0x%02h",
				$time, what, r, got, exp);
		end
	endtask

	initial begin
		logic [gf_m-1:0] v;
		logic [rf_addr_w-1:0] ra;
		logic [rf_addr_w-1:0] rb;
		logic [rf_addr_w-1:0] rd;
		logic [31:0] pick;
		seed = 32'hbf77_3244;
		reset = 1'b1;
		cmd_start = 1'b0;
		cmd_op = op_write;
		cmd_a = '0;
		cmd_b = '0;
		cmd_dst = '0;
		cmd_imm = '0;
		for (int i = 0; i < rf_depth; i++)
			shadow[i] = '0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		checks++;
		assert (cmd_ready === 1'b1 && rd_valid === 1'b0)
		else begin
			errors++;
			$display("Error: %0d ns: after reset cmd_ready is %b and rd_valid is %b",
				$time, cmd_ready, rd_valid);
		end

		for (int r = 0; r < rf_depth; r++)
			read_check(r[rf_addr_w-1:0], '0, "reset value");
		for (int r = 0; r < rf_depth; r++) begin
			v = rand_val();
			write_reg(r[rf_addr_w-1:0], v);
			read_check(r[rf_addr_w-1:0], v, "write then read");
		end

		for (int i = 0; i < 6; i++) begin
			write_reg(4'd1, rand_val());
			write_reg(4'd2, rand_val());
			issue(op_mul, 4'd1, 4'd2, 4'd3, '0);
			read_check(4'd3, shadow[3], "product");
		end
		write_reg(4'd4, 7'h01);
		issue(op_mul, 4'd1, 4'd4, 4'd5, '0);
		read_check(4'd5, shadow[1], "multiply by one");
		write_reg(4'd6, '0);
		issue(op_mul, 4'd6, 4'd1, 4'd7, '0);
		read_check(4'd7, '0, "multiply by zero");

		// The Frobenius map has order seven in GF(2^7).
		v = rand_nonzero();
		write_reg(4'd8, v);
		issue(op_sqr, 4'd8, '0, 4'd9, '0);
		read_check(4'd9, shadow[9], "square");
		repeat (gf_m - 1)
			issue(op_sqr, 4'd9, '0, 4'd9, '0);
		read_check(4'd9, v, "seven squarings");

		for (int i = 0; i < 4; i++) begin
			v = rand_nonzero();
			write_reg(4'd10, v);
			issue(op_inv, 4'd10, '0, 4'd11, '0);
			read_check(4'd11, shadow[11], "inverse");
			issue(op_mul, 4'd11, 4'd10, 4'd12, '0);
			read_check(4'd12, 7'h01, "inverse times value");
		end
		write_reg(4'd13, '0);
		issue(op_inv, 4'd13, '0, 4'd14, '0);
		read_check(4'd14, '0, "inverse of zero");

		// Mixed stream with both engines in flight and shared registers.
		while (cmd_count < n_cmds - rf_depth) begin
			pick = next_rand() % 32'd20;
			ra = rand_reg();
			rb = rand_reg();
			rd = rand_reg();
			if (pick < 7)
				issue(op_mul, ra, rb, rd, '0);
			else if (pick < 11)
				issue(op_inv, ra, '0, rd, '0);
			else if (pick < 14)
				issue(op_sqr, ra, '0, rd, '0);
			else if (pick < 17)
				write_reg(rd, rand_val());
			else
				read_check(ra, shadow[ra], "mixed stream");
		end

		for (int r = 0; r < rf_depth; r++)
			read_check(r[rf_addr_w-1:0], shadow[r], "final sweep");
		repeat (2) @(negedge clk);

		checks++;
		assert (rd_pulses == n_reads)
		else begin
			errors++;
			$display("Error: %0d ns: saw %0d rd_valid cycles for %0d reads",
				$time, rd_pulses, n_reads);
		end

		$display("Checks: %0d, errors: %0d, commands: %0d", checks, errors, cmd_count);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end
endmodule

//--- sources.f
gf_pkg.sv
rf_bus_if.sv
gf_regfile.sv
rf_arbiter.sv
gf_mul_engine.sv
gf_inv_engine.sv
gf_cmd_ctrl.sv
gf_coproc.sv
tb_gf_coproc.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_gf_coproc \
	-f sources.f > build.log 2>&1 || { cat build.log; echo "Build failed."; exit 1; }
./obj_dir/Vtb_gf_coproc > sim.log 2>&1
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0
